// ==== list.f ====
source/icrc_pkg.sv
source/crc32_lanes.sv
source/icrc_tail_format.sv
source/icrc_insert_ctrl.sv
source/axis_out_skid.sv
source/icrc_insert_64.sv
dv/icrc_tb_pkg.sv
dv/icrc_insert_tb.sv

// ==== dv/icrc_insert_tb.sv ====
module icrc_insert_tb
    import icrc_tb_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ns;

    localparam int NUM_TESTS = 21;

    logic        clk = 1'b0;
    logic        rst;
    logic [63:0] s_axis_tdata;
    logic [7:0]  s_axis_tkeep;
    logic        s_axis_tvalid;
    logic        s_axis_tready;
    logic        s_axis_tlast;
    logic        s_axis_tuser;
    logic [63:0] m_axis_tdata;
    logic [7:0]  m_axis_tkeep;
    logic        m_axis_tvalid;
    logic        m_axis_tready;
    logic        m_axis_tlast;
    logic        m_axis_tuser;
    logic        busy;

    integer    seed = 32'h2d85;
    int        cur_gap;
    int        cur_stall;
    int        cycles = 0;
    int        cycle_limit;
    exp_beat_t exp_queue [$];
    exp_beat_t out_exp;

    // name, length, abort, input gap %, output stall %
    frame_t tests [NUM_TESTS] = '{
        '{"single_1", 1, 0, 0, 0}, '{"single_2", 2, 0, 0, 0},
        '{"single_3", 3, 0, 0, 0}, '{"single_4", 4, 0, 0, 0},
        '{"single_5", 5, 0, 0, 0}, '{"single_6", 6, 0, 0, 0},
        '{"single_7", 7, 0, 0, 0}, '{"single_8", 8, 0, 0, 0},
        '{"multi_9", 9, 0, 0, 0}, '{"multi_12", 12, 0, 0, 0},
        '{"multi_16", 16, 0, 0, 0}, '{"multi_21", 21, 0, 0, 0},
        '{"multi_64", 64, 0, 0, 0},
        '{"abort_13", 13, 1, 0, 0}, '{"after_abort_20", 20, 0, 0, 0},
        '{"abort_3", 3, 1, 0, 0}, '{"after_abort_7", 7, 0, 0, 0},
        '{"stall_30", 30, 0, 30, 30}, '{"stall_45", 45, 0, 20, 40},
        '{"stall_17", 17, 0, 40, 25}, '{"stall_8", 8, 0, 30, 30}
    };

    icrc_insert_64 icrc_insert_64_inst (.*);

    always #10 clk = ~clk;

    task automatic stop_failed();
        $display("sim failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_value(string test_name, string field, logic [63:0] expected_value,
                               logic [63:0] actual_value);
        if (expected_value !== actual_value) begin
            $display("FAILED %s %s expected %h actual %h", test_name, field,
                     expected_value, actual_value);
            stop_failed();
        end
    endtask

    function automatic bit chance(int pct);
        logic [31:0] r;
        r = $random(seed);
        return (r % 100) < pct;
    endfunction

    // one clock, stall pattern changes on the falling edge
    task automatic next_cycle(output logic in_taken);
        @(posedge clk);
        in_taken = s_axis_tvalid && s_axis_tready;
        @(negedge clk);
        m_axis_tready = !chance(cur_stall);
    endtask

    task automatic send_packet(int t);
        byte_q_t   payload;
        byte_q_t   out_bytes;
        exp_beat_t e;
        int        nbeats;
        logic      taken;
        logic [63:0] data;
        logic [7:0]  keep;
        cur_gap = tests[t].gap_pct;
        cur_stall = tests[t].stall_pct;
        for (int i = 0; i < tests[t].len; i++) begin
            payload.push_back(8'($random(seed)));
        end

        out_bytes = expected_bytes(payload, tests[t].abort);
        nbeats = beat_count(out_bytes.size());
        for (int b = 0; b < nbeats; b++) begin
            e = '0;
            for (int l = 0; l < 8; l++) begin
                if (b*8 + l < out_bytes.size()) begin
                    e.data[l*8 +: 8] = out_bytes[b*8 + l];
                    e.keep[l] = 1'b1;
                end
            end
            e.last = (b == nbeats - 1);
            e.user = tests[t].abort && e.last;
            e.test_idx = 8'(t);
            exp_queue.push_back(e);
        end

        nbeats = beat_count(tests[t].len);
        for (int b = 0; b < nbeats; b++) begin
            // junk in lanes past the end, must come out as zero
            data = {$random(seed), $random(seed)};
            keep = '0;
            for (int l = 0; l < 8; l++) begin
                if (b*8 + l < tests[t].len) begin
                    data[l*8 +: 8] = payload[b*8 + l];
                    keep[l] = 1'b1;
                end
            end
            while (chance(cur_gap)) begin
                s_axis_tvalid = 1'b0;
                next_cycle(taken);
            end
            s_axis_tdata = data;
            s_axis_tkeep = keep;
            s_axis_tlast = (b == nbeats - 1);
            s_axis_tuser = tests[t].abort && (b == nbeats - 1);
            s_axis_tvalid = 1'b1;
            taken = 1'b0;
            while (!taken) begin
                next_cycle(taken);
            end
            if (b != nbeats - 1) begin
                check_value(tests[t].name, "busy", 1, busy);
            end
        end
    endtask

    function automatic int total_beats();
        int total;
        total = 0;
        foreach (tests[t]) begin
            total += beat_count(tests[t].len);
            total += beat_count(tests[t].len + (tests[t].abort ? 0 : 4));
        end
        return total;
    endfunction

    always @(posedge clk) begin
        if (!rst && m_axis_tvalid && m_axis_tready) begin
            if (exp_queue.size() == 0) begin
                $display("output beat arrived when no beat was expected");
                stop_failed();
            end else begin
                out_exp = exp_queue.pop_front();
                check_value(tests[out_exp.test_idx].name, "tdata", out_exp.data, m_axis_tdata);
                check_value(tests[out_exp.test_idx].name, "tkeep", out_exp.keep, m_axis_tkeep);
                check_value(tests[out_exp.test_idx].name, "tlast", out_exp.last, m_axis_tlast);
                check_value(tests[out_exp.test_idx].name, "tuser", out_exp.user, m_axis_tuser);
            end
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > cycle_limit) begin
            $display("timeout after %0d cycles, traffic did not complete", cycles);
            stop_failed();
        end
    end

    initial begin
        logic taken;
        cycle_limit = 4 * total_beats() + 200;
        rst = 1'b1;
        s_axis_tdata = '0;
        s_axis_tkeep = '0;
        s_axis_tvalid = 1'b0;
        s_axis_tlast = 1'b0;
        s_axis_tuser = 1'b0;
        m_axis_tready = 1'b0;
        cur_gap = 0;
        cur_stall = 0;

        repeat (4) @(posedge clk);
        @(negedge clk);
        check_value("reset", "tvalid", 0, m_axis_tvalid);
        check_value("reset", "tready", 0, s_axis_tready);
        check_value("reset", "busy", 0, busy);
        rst = 1'b0;
        m_axis_tready = 1'b1;

        for (int t = 0; t < NUM_TESTS; t++) begin
            send_packet(t);
        end

        // let the output drain
        s_axis_tvalid = 1'b0;
        cur_stall = 0;
        while (exp_queue.size() != 0) begin
            next_cycle(taken);
        end
        repeat (2) next_cycle(taken);
        check_value("drain", "busy", 0, busy);
        check_value("drain", "tvalid", 0, m_axis_tvalid);

        $display("sim passed");
        $finish;
    end

endmodule

// ==== dv/icrc_tb_pkg.sv ====
package icrc_tb_pkg;

    timeunit 1ns;
    timeprecision 1ns;

    // 04c11db7 with its bits reversed
    localparam logic [31:0] REF_POLY = 32'hedb88320;
    localparam logic [31:0] REF_INIT = 32'hdebb20e3;

    typedef logic [7:0] byte_q_t [$];

    typedef struct {
        string name;
        int    len;
        bit    abort;
        int    gap_pct;
        int    stall_pct;
    } frame_t;

    typedef struct packed {
        logic [63:0] data;
        logic [7:0]  keep;
        logic        last;
        logic        user;
        logic [7:0]  test_idx;
    } exp_beat_t;

    // bitwise reflected crc, one byte at a time
    function automatic logic [31:0] ref_crc(byte_q_t bytes);
        logic [31:0] crc;
        crc = REF_INIT;
        foreach (bytes[i]) begin
            crc = crc ^ {24'd0, bytes[i]};
            for (int b = 0; b < 8; b++) begin
                crc = crc[0] ? ((crc >> 1) ^ REF_POLY) : (crc >> 1);
            end
        end
        return crc;
    endfunction

    // payload then inverted crc lsb first, nothing added on abort
    function automatic byte_q_t expected_bytes(byte_q_t payload, bit abort);
        byte_q_t result;
        logic [31:0] icrc;
        result = payload;
        if (!abort) begin
            icrc = ~ref_crc(payload);
            for (int i = 0; i < 4; i++) begin
                result.push_back(icrc[i*8 +: 8]);
            end
        end
        return result;
    endfunction

    function automatic int beat_count(int num_bytes);
        return (num_bytes + 7) / 8;
    endfunction

endpackage

// ==== source/icrc_insert_64.sv ====
module icrc_insert_64
    import icrc_pkg::*;
(
    input  logic  clk,
    input  logic  rst,

    input  data_t s_axis_tdata,
    input  keep_t s_axis_tkeep,
    input  logic  s_axis_tvalid,
    output logic  s_axis_tready,
    input  logic  s_axis_tlast,
    input  logic  s_axis_tuser,

    output data_t m_axis_tdata,
    output keep_t m_axis_tkeep,
    output logic  m_axis_tvalid,
    input  logic  m_axis_tready,
    output logic  m_axis_tlast,
    output logic  m_axis_tuser,

    output logic  busy
);

    axis_beat_t s_beat;
    axis_beat_t m_beat;
    axis_beat_t in_beat;
    axis_beat_t tail_beat;
    axis_beat_t spill_beat;
    axis_beat_t out_beat;
    logic       out_valid;
    logic       ready_early;
    logic       crc_clear;
    logic       crc_update;

    crc_t [BYTES_PER_BEAT-1:0] lane_crc;

    assign s_beat = '{data: s_axis_tdata, keep: s_axis_tkeep, last: s_axis_tlast,
                      user: s_axis_tuser};

    assign m_axis_tdata = m_beat.data;
    assign m_axis_tkeep = m_beat.keep;
    assign m_axis_tlast = m_beat.last;
    assign m_axis_tuser = m_beat.user;

    icrc_insert_ctrl ctrl_inst (
        .clk         (clk),
        .rst         (rst),
        .s_beat      (s_beat),
        .s_valid     (s_axis_tvalid),
        .s_ready     (s_axis_tready),
        .ready_early (ready_early),
        .tail_beat   (tail_beat),
        .spill_beat  (spill_beat),
        .in_beat     (in_beat),
        .crc_clear   (crc_clear),
        .crc_update  (crc_update),
        .out_beat    (out_beat),
        .out_valid   (out_valid),
        .busy        (busy)
    );

    crc32_lanes crc_inst (
        .clk        (clk),
        .rst        (rst),
        .data       (in_beat.data),
        .crc_clear  (crc_clear),
        .crc_update (crc_update),
        .lane_crc   (lane_crc)
    );

    icrc_tail_format tail_inst (
        .beat       (in_beat),
        .lane_crc   (lane_crc),
        .tail_beat  (tail_beat),
        .spill_beat (spill_beat)
    );

    axis_out_skid skid_inst (
        .clk         (clk),
        .rst         (rst),
        .in_beat     (out_beat),
        .in_valid    (out_valid),
        .ready_early (ready_early),
        .m_beat      (m_beat),
        .m_valid     (m_axis_tvalid),
        .m_ready     (m_axis_tready)
    );

endmodule

// ==== source/axis_out_skid.sv ====
module axis_out_skid
    import icrc_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  axis_beat_t in_beat,
    input  logic       in_valid,
    output logic       ready_early,
    output axis_beat_t m_beat,
    output logic       m_valid,
    input  logic       m_ready
);

    logic       in_ready;
    logic       m_valid_next;
    logic       temp_valid;
    logic       temp_valid_next;
    axis_beat_t temp_beat;

    logic store_in_to_out;
    logic store_in_to_temp;
    logic store_temp_to_out;

    // room next cycle if downstream takes or nothing is held
    assign ready_early = m_ready || (!temp_valid && !m_valid);

    always_comb begin
        m_valid_next = m_valid;
        temp_valid_next = temp_valid;
        store_in_to_out = 1'b0;
        store_in_to_temp = 1'b0;
        store_temp_to_out = 1'b0;

        if (in_ready) begin
            if (m_ready || !m_valid) begin
                m_valid_next = in_valid;
                store_in_to_out = 1'b1;
            end else begin
                // output stalled, park it
                temp_valid_next = in_valid;
                store_in_to_temp = 1'b1;
            end
        end else if (m_ready) begin
            m_valid_next = temp_valid;
            temp_valid_next = 1'b0;
            store_temp_to_out = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            m_valid <= 1'b0;
            temp_valid <= 1'b0;
            in_ready <= 1'b0;
        end else begin
            m_valid <= m_valid_next;
            temp_valid <= temp_valid_next;
            in_ready <= ready_early;
        end
    end

    always_ff @(posedge clk) begin
        if (store_in_to_out) begin
            m_beat <= in_beat;
        end else if (store_temp_to_out) begin
            m_beat <= temp_beat;
        end

        if (store_in_to_temp) begin
            temp_beat <= in_beat;
        end
    end

endmodule

// ==== source/icrc_insert_ctrl.sv ====
module icrc_insert_ctrl
    import icrc_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  axis_beat_t s_beat,
    input  logic       s_valid,
    output logic       s_ready,
    input  logic       ready_early,
    input  axis_beat_t tail_beat,
    input  axis_beat_t spill_beat,
    output axis_beat_t in_beat,
    output logic       crc_clear,
    output logic       crc_update,
    output axis_beat_t out_beat,
    output logic       out_valid,
    output logic       busy
);

    ins_state_t state;
    ins_state_t state_next;

    logic       s_ready_next;
    logic       ready_reg;
    logic       store_spill;
    logic       in_xfer;
    axis_beat_t spill_reg;
    data_t      data_masked;

    // zero the lanes with keep low
    always_comb begin
        for (int i = 0; i < BYTES_PER_BEAT; i++) begin
            data_masked[i*8 +: 8] = s_beat.keep[i] ? s_beat.data[i*8 +: 8] : 8'd0;
        end
        in_beat.data = data_masked;
        in_beat.keep = s_beat.keep;
        in_beat.last = s_beat.last;
        in_beat.user = s_beat.user;
    end

    assign in_xfer = s_valid && s_ready;

    always_comb begin
        state_next = state;
        s_ready_next = 1'b0;
        crc_clear = 1'b0;
        crc_update = 1'b0;
        store_spill = 1'b0;

        out_beat = in_beat;
        out_beat.last = 1'b0;
        out_beat.user = 1'b0;
        out_valid = 1'b0;

        case (state)
            IDLE, PAYLOAD: begin
                s_ready_next = ready_early;
                out_valid = in_xfer;
                crc_clear = (state == IDLE);

                if (in_xfer) begin
                    crc_clear = 1'b0;
                    crc_update = 1'b1;
                    state_next = PAYLOAD;

                    if (s_beat.last) begin
                        crc_clear = 1'b1;
                        state_next = IDLE;
                        if (s_beat.user) begin
                            // abort, pass through without crc
                            out_beat.last = 1'b1;
                            out_beat.user = 1'b1;
                        end else begin
                            out_beat = tail_beat;
                            if (spill_beat.keep != '0) begin
                                store_spill = 1'b1;
                                s_ready_next = 1'b0;
                                state_next = TAIL;
                            end
                        end
                    end
                end
            end
            TAIL: begin
                // remaining crc bytes
                out_beat = spill_reg;
                out_valid = 1'b1;
                crc_clear = 1'b1;
                if (ready_reg) begin
                    s_ready_next = ready_early;
                    state_next = IDLE;
                end
            end
            default: begin
                state_next = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
            s_ready <= 1'b0;
            ready_reg <= 1'b0;
            busy <= 1'b0;
        end else begin
            state <= state_next;
            s_ready <= s_ready_next;
            ready_reg <= ready_early;
            busy <= (state_next != IDLE);
        end
    end

    always_ff @(posedge clk) begin
        if (store_spill) begin
            spill_reg <= spill_beat;
        end
    end

endmodule

// ==== source/icrc_tail_format.sv ====
module icrc_tail_format
    import icrc_pkg::*;
(
    input  axis_beat_t                     beat,
    input  crc_t [BYTES_PER_BEAT-1:0]      lane_crc,
    output axis_beat_t                     tail_beat,
    output axis_beat_t                     spill_beat
);

    byte_count_t byte_count;
    byte_count_t crc_sel;
    byte_count_t tail_count;
    byte_count_t spill_count;
    crc_t        crc_out;
    logic        spill;
    logic [2*BYTES_PER_BEAT*8-1:0] merged;

    always_comb begin
        byte_count = keep_count(beat.keep);

        // empty last beat not expected, keep the select in range
        if (byte_count == '0) begin
            crc_sel = '0;
        end else begin
            crc_sel = byte_count - 4'd1;
        end
        crc_out = ~lane_crc[crc_sel[2:0]];

        spill = (byte_count > 4'd4);
        if (spill) begin
            tail_count = 4'd8;
            spill_count = byte_count - 4'd4;
        end else begin
            tail_count = byte_count + 4'd4;
            spill_count = '0;
        end
    end

    // crc bytes land right after the payload, lsb first
    always_comb begin
        merged = {{(2*BYTES_PER_BEAT*8-32){1'b0}}, crc_out} << {byte_count, 3'b000};
        merged = merged | {{(BYTES_PER_BEAT*8){1'b0}}, beat.data};
    end

    always_comb begin
        tail_beat.data = merged[BYTES_PER_BEAT*8-1:0];
        tail_beat.keep = count_keep(tail_count);
        tail_beat.last = !spill;
        tail_beat.user = 1'b0;

        spill_beat.data = merged[2*BYTES_PER_BEAT*8-1:BYTES_PER_BEAT*8];
        spill_beat.keep = count_keep(spill_count);
        spill_beat.last = spill;
        spill_beat.user = 1'b0;
    end

endmodule

// ==== source/crc32_lanes.sv ====
module crc32_lanes
    import icrc_pkg::*;
(
    input  logic                           clk,
    input  logic                           rst,
    input  data_t                          data,
    input  logic                           crc_clear,
    input  logic                           crc_update,
    output crc_t [BYTES_PER_BEAT-1:0]      lane_crc
);

    crc_t crc_reg;

    function automatic crc_t poly_reflected();
        crc_t poly;
        for (int i = 0; i < 32; i++) begin
            poly[i] = CRC_POLY[31-i];
        end
        return poly;
    endfunction

    // one byte through the reflected crc, lsb first
    function automatic crc_t crc_byte(crc_t crc_in, logic [7:0] data_byte);
        crc_t crc;
        crc = crc_in ^ {24'd0, data_byte};
        for (int b = 0; b < 8; b++) begin
            if (crc[0]) begin
                crc = (crc >> 1) ^ poly_reflected();
            end else begin
                crc = crc >> 1;
            end
        end
        return crc;
    endfunction

    // lane n sees bytes 0..n
    always_comb begin
        crc_t state;
        state = crc_reg;
        for (int n = 0; n < BYTES_PER_BEAT; n++) begin
            state = crc_byte(state, data[n*8 +: 8]);
            lane_crc[n] = state;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || crc_clear) begin
            crc_reg <= CRC_INIT;
        end else if (crc_update) begin
            crc_reg <= lane_crc[BYTES_PER_BEAT-1];
        end
    end

endmodule

// ==== source/icrc_pkg.sv ====
package icrc_pkg;

    localparam int BYTES_PER_BEAT = 8;

    typedef logic [BYTES_PER_BEAT*8-1:0] data_t;
    typedef logic [BYTES_PER_BEAT-1:0] keep_t;
    typedef logic [31:0] crc_t;
    typedef logic [3:0] byte_count_t;

    // normal form, reflected where used
    localparam crc_t CRC_POLY = 32'h04c11db7;
    localparam crc_t CRC_INIT = 32'hdebb20e3;

    typedef struct packed {
        data_t data;
        keep_t keep;
        logic  last;
        logic  user;
    } axis_beat_t;

    typedef enum logic [1:0] {
        IDLE,
        PAYLOAD,
        TAIL
    } ins_state_t;

    // keep is contiguous from lane 0
    function automatic byte_count_t keep_count(keep_t keep);
        byte_count_t count;
        count = '0;
        for (int i = 0; i < BYTES_PER_BEAT; i++) begin
            if (keep[i]) begin
                count = byte_count_t'(i + 1);
            end
        end
        return count;
    endfunction

    function automatic keep_t count_keep(byte_count_t count);
        keep_t keep;
        for (int i = 0; i < BYTES_PER_BEAT; i++) begin
            keep[i] = (i < count);
        end
        return keep;
    endfunction

endpackage
